// ==== verilog/axi_burst_pkg.sv ====
/*
 * AXI burst definitions
 * Field widths of the AXI4 address channels, the beat-size type and
 * the state encoding shared by the write and read burst engines
 */
package axi_burst_pkg;

   // AXI channel field widths
   localparam int unsigned AXI_ID_W   = 8;
   localparam int unsigned AXI_LEN_W  = 8;
   localparam int unsigned AXI_SIZE_W = 3;

   // Beat size as log2 of the byte count
   typedef logic [AXI_SIZE_W-1:0] beat_size_t;

   typedef enum logic [1:0] {
      // Waiting for an address
      BURST_IDLE = 2'd0,
      // Beat transfer on the AXI side
      BURST_DATA = 2'd1,
      // Current beat is in flight on the IOb side
      BURST_RESP = 2'd2
   } burst_state_e;

endpackage

// ==== verilog/iob_bus_pkg.sv ====
/*
 * IOb bus definitions
 * Address, data and strobe widths of the IOb port and the arbiter grant states
 */
package iob_bus_pkg;

   // Byte address and data widths
   localparam int unsigned IOB_ADDR_W = 32;
   localparam int unsigned IOB_DATA_W = 32;
   localparam int unsigned IOB_STRB_W = IOB_DATA_W / 8;

   typedef enum logic [1:0] {
      // Bus is free
      GNT_NONE    = 2'd0,
      // Write engine owns the bus until acceptance
      GNT_WR      = 2'd1,
      // Read engine owns the bus, request not yet accepted
      GNT_RD      = 2'd2,
      // Read accepted, data still to come
      GNT_RD_WAIT = 2'd3
   } grant_e;

endpackage

// ==== verilog/axi_wr_burst.sv ====
/*
 * AXI4 write burst engine
 * Splits an incrementing write burst into one IOb write per beat and
 * returns a single write response at the end of the burst
 */
`timescale 1ns/1ns

module axi_wr_burst (
   input  logic                                 clk_i,
   input  logic                                 arst_i,
   input  logic [axi_burst_pkg::AXI_ID_W-1:0]   awid_i,
   input  logic [iob_bus_pkg::IOB_ADDR_W-1:0]   awaddr_i,
   input  logic [axi_burst_pkg::AXI_LEN_W-1:0]  awlen_i,
   input  logic [axi_burst_pkg::AXI_SIZE_W-1:0] awsize_i,
   input  logic                                 awvalid_i,
   output logic                                 awready_o,
   input  logic [iob_bus_pkg::IOB_DATA_W-1:0]   wdata_i,
   input  logic [iob_bus_pkg::IOB_STRB_W-1:0]   wstrb_i,
   input  logic                                 wvalid_i,
   output logic                                 wready_o,
   output logic [axi_burst_pkg::AXI_ID_W-1:0]   bid_o,
   output logic                                 bvalid_o,
   input  logic                                 bready_i,
   output logic                                 req_o,
   output logic [iob_bus_pkg::IOB_ADDR_W-1:0]   req_addr_o,
   output logic [iob_bus_pkg::IOB_DATA_W-1:0]   req_wdata_o,
   output logic [iob_bus_pkg::IOB_STRB_W-1:0]   req_wstrb_o,
   input  logic                                 done_i
);
   import axi_burst_pkg::*;
   import iob_bus_pkg::*;

   burst_state_e          state_q;
   burst_state_e          state_d;
   logic                  awready_d;
   logic                  wready_d;
   logic                  bvalid_d;
   logic                  req_d;
   logic [AXI_ID_W-1:0]   id_q;
   logic [IOB_ADDR_W-1:0] addr_q;
   logic [AXI_LEN_W-1:0]  cnt_q;
   beat_size_t            size_q;
   logic [IOB_DATA_W-1:0] wdata_q;
   logic [IOB_STRB_W-1:0] wstrb_q;
   logic                  aw_hs;
   logic                  w_hs;
   logic                  beat_done;
   logic                  last_beat;

   assign aw_hs     = awready_o & awvalid_i;
   assign w_hs      = wready_o & wvalid_i;
   assign last_beat = (cnt_q == '0);

   // A beat ends on IOb acceptance, or right away when its strobe is empty
   assign beat_done = ((state_q == BURST_RESP) & done_i) | (w_hs & (wstrb_i == '0));

   always_comb begin
      state_d   = state_q;
      awready_d = 1'b0;
      wready_d  = 1'b0;
      bvalid_d  = bvalid_o & ~bready_i;
      req_d     = req_o;

      case (state_q)
         BURST_IDLE: begin
            // No new address while a response is still pending
            awready_d = ~bvalid_d & ~aw_hs;
            if (aw_hs) begin
               wready_d = 1'b1;
               state_d  = BURST_DATA;
            end
         end
         BURST_DATA: begin
            wready_d = ~w_hs;
            if (w_hs && wstrb_i != '0) begin
               req_d   = 1'b1;
               state_d = BURST_RESP;
            end
         end
         BURST_RESP: begin
            if (done_i) begin
               req_d = 1'b0;
            end
         end
         default: begin
            state_d = BURST_IDLE;
         end
      endcase

      if (beat_done) begin
         if (last_beat) begin
            bvalid_d = 1'b1;
            state_d  = BURST_IDLE;
         end else begin
            wready_d = 1'b1;
            state_d  = BURST_DATA;
         end
      end
   end

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state_q   <= BURST_IDLE;
         awready_o <= 1'b0;
         wready_o  <= 1'b0;
         bvalid_o  <= 1'b0;
         req_o     <= 1'b0;
      end else begin
         state_q   <= state_d;
         awready_o <= awready_d;
         wready_o  <= wready_d;
         bvalid_o  <= bvalid_d;
         req_o     <= req_d;
      end
   end

   always_ff @(posedge clk_i) begin
      if (aw_hs) begin
         id_q   <= awid_i;
         addr_q <= awaddr_i;
         cnt_q  <= awlen_i;
         size_q <= awsize_i;
      end else if (beat_done) begin
         addr_q <= addr_q + (IOB_ADDR_W'(1) << size_q);
         cnt_q  <= cnt_q - 1'b1;
      end
      if (w_hs) begin
         wdata_q <= wdata_i;
         wstrb_q <= wstrb_i;
      end
   end

   assign bid_o       = id_q;
   assign req_addr_o  = addr_q;
   assign req_wdata_o = wdata_q;
   assign req_wstrb_o = wstrb_q;

endmodule

// ==== verilog/axi_rd_burst.sv ====
/*
 * AXI4 read burst engine
 * Issues one IOb read per beat of an incrementing burst and returns
 * each word as an R beat, with rlast on the final one
 */
`timescale 1ns/1ns

module axi_rd_burst (
   input  logic                                 clk_i,
   input  logic                                 arst_i,
   input  logic [axi_burst_pkg::AXI_ID_W-1:0]   arid_i,
   input  logic [iob_bus_pkg::IOB_ADDR_W-1:0]   araddr_i,
   input  logic [axi_burst_pkg::AXI_LEN_W-1:0]  arlen_i,
   input  logic [axi_burst_pkg::AXI_SIZE_W-1:0] arsize_i,
   input  logic                                 arvalid_i,
   output logic                                 arready_o,
   output logic [axi_burst_pkg::AXI_ID_W-1:0]   rid_o,
   output logic [iob_bus_pkg::IOB_DATA_W-1:0]   rdata_o,
   output logic                                 rlast_o,
   output logic                                 rvalid_o,
   input  logic                                 rready_i,
   output logic                                 req_o,
   output logic [iob_bus_pkg::IOB_ADDR_W-1:0]   req_addr_o,
   input  logic                                 done_i,
   input  logic [iob_bus_pkg::IOB_DATA_W-1:0]   rdata_i
);
   import axi_burst_pkg::*;
   import iob_bus_pkg::*;

   burst_state_e          state_q;
   burst_state_e          state_d;
   logic                  arready_d;
   logic                  rvalid_d;
   logic                  rlast_d;
   logic                  req_d;
   logic [AXI_ID_W-1:0]   id_q;
   logic [IOB_ADDR_W-1:0] addr_q;
   logic [AXI_LEN_W-1:0]  cnt_q;
   beat_size_t            size_q;
   logic [IOB_DATA_W-1:0] rdata_q;
   logic                  ar_hs;
   logic                  r_hs;
   logic                  last_beat;

   assign ar_hs     = arready_o & arvalid_i;
   assign r_hs      = rvalid_o & rready_i;
   assign last_beat = (cnt_q == '0);

   always_comb begin
      state_d   = state_q;
      arready_d = 1'b0;
      rvalid_d  = rvalid_o & ~rready_i;
      rlast_d   = rlast_o;
      req_d     = req_o;

      case (state_q)
         BURST_IDLE: begin
            arready_d = ~ar_hs;
            if (ar_hs) begin
               req_d   = 1'b1;
               state_d = BURST_RESP;
            end
         end
         BURST_RESP: begin
            // Word is back from IOb, present it as an R beat
            if (done_i) begin
               req_d    = 1'b0;
               rvalid_d = 1'b1;
               rlast_d  = last_beat;
               state_d  = BURST_DATA;
            end
         end
         BURST_DATA: begin
            // Next read waits for the master to take this beat
            if (r_hs) begin
               if (last_beat) begin
                  arready_d = 1'b1;
                  state_d   = BURST_IDLE;
               end else begin
                  req_d   = 1'b1;
                  state_d = BURST_RESP;
               end
            end
         end
         default: begin
            state_d = BURST_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state_q   <= BURST_IDLE;
         arready_o <= 1'b0;
         rvalid_o  <= 1'b0;
         rlast_o   <= 1'b0;
         req_o     <= 1'b0;
      end else begin
         state_q   <= state_d;
         arready_o <= arready_d;
         rvalid_o  <= rvalid_d;
         rlast_o   <= rlast_d;
         req_o     <= req_d;
      end
   end

   always_ff @(posedge clk_i) begin
      if (ar_hs) begin
         id_q   <= arid_i;
         addr_q <= araddr_i;
         cnt_q  <= arlen_i;
         size_q <= arsize_i;
      end else if (r_hs && !last_beat) begin
         addr_q <= addr_q + (IOB_ADDR_W'(1) << size_q);
         cnt_q  <= cnt_q - 1'b1;
      end
      if (state_q == BURST_RESP && done_i) begin
         rdata_q <= rdata_i;
      end
   end

   assign rid_o      = id_q;
   assign rdata_o    = rdata_q;
   assign req_addr_o = addr_q;

endmodule

// ==== verilog/iob_bus_arbiter.sv ====
/*
 * IOb bus arbiter
 * Shares one IOb master port between the write and read engines,
 * alternating between them when both request at once
 */
`timescale 1ns/1ns

module iob_bus_arbiter (
   input  logic                               clk_i,
   input  logic                               arst_i,
   input  logic                               wr_req_i,
   input  logic [iob_bus_pkg::IOB_ADDR_W-1:0] wr_addr_i,
   input  logic [iob_bus_pkg::IOB_DATA_W-1:0] wr_wdata_i,
   input  logic [iob_bus_pkg::IOB_STRB_W-1:0] wr_wstrb_i,
   output logic                               wr_done_o,
   input  logic                               rd_req_i,
   input  logic [iob_bus_pkg::IOB_ADDR_W-1:0] rd_addr_i,
   output logic                               rd_done_o,
   output logic                               iob_valid_o,
   output logic [iob_bus_pkg::IOB_ADDR_W-1:0] iob_addr_o,
   output logic [iob_bus_pkg::IOB_DATA_W-1:0] iob_wdata_o,
   output logic [iob_bus_pkg::IOB_STRB_W-1:0] iob_wstrb_o,
   input  logic                               iob_ready_i,
   input  logic                               iob_rvalid_i
);
   import iob_bus_pkg::*;

   grant_e gnt_q;
   grant_e gnt_d;
   logic   last_wr_q;
   logic   last_wr_d;
   logic   sel_wr;
   logic   sel_rd;

   // Owner of the port this cycle, a fresh grant takes effect at once
   always_comb begin
      sel_wr = 1'b0;
      sel_rd = 1'b0;
      case (gnt_q)
         GNT_NONE: begin
            sel_wr = wr_req_i & (~rd_req_i | ~last_wr_q);
            sel_rd = rd_req_i & ~sel_wr;
         end
         GNT_WR:  sel_wr = 1'b1;
         GNT_RD:  sel_rd = 1'b1;
         default: ;
      endcase
   end

   always_comb begin
      gnt_d     = gnt_q;
      last_wr_d = last_wr_q;
      if (gnt_q == GNT_NONE && (sel_wr || sel_rd)) begin
         last_wr_d = sel_wr;
      end
      if (sel_wr) begin
         gnt_d = iob_ready_i ? GNT_NONE : GNT_WR;
      end else if (sel_rd) begin
         gnt_d = iob_ready_i ? GNT_RD_WAIT : GNT_RD;
      end else if (gnt_q == GNT_RD_WAIT && iob_rvalid_i) begin
         gnt_d = GNT_NONE;
      end
   end

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         gnt_q     <= GNT_NONE;
         last_wr_q <= 1'b0;
      end else begin
         gnt_q     <= gnt_d;
         last_wr_q <= last_wr_d;
      end
   end

   assign iob_valid_o = (sel_wr & wr_req_i) | (sel_rd & rd_req_i);
   assign iob_addr_o  = sel_rd ? rd_addr_i : wr_addr_i;
   assign iob_wdata_o = wr_wdata_i;
   assign iob_wstrb_o = sel_wr ? wr_wstrb_i : '0;
   assign wr_done_o   = sel_wr & iob_ready_i;
   assign rd_done_o   = (gnt_q == GNT_RD_WAIT) & iob_rvalid_i;

endmodule

// ==== verilog/axi2iob_top.sv ====
/*
 * AXI4 to IOb adapter
 * Write and read burst engines sharing one IOb master port
 */
`timescale 1ns/1ns

module axi2iob_top (
   input  logic                                 clk_i,
   input  logic                                 arst_i,
   input  logic [axi_burst_pkg::AXI_ID_W-1:0]   s_axi_awid_i,
   input  logic [iob_bus_pkg::IOB_ADDR_W-1:0]   s_axi_awaddr_i,
   input  logic [axi_burst_pkg::AXI_LEN_W-1:0]  s_axi_awlen_i,
   input  logic [axi_burst_pkg::AXI_SIZE_W-1:0] s_axi_awsize_i,
   input  logic                                 s_axi_awvalid_i,
   output logic                                 s_axi_awready_o,
   input  logic [iob_bus_pkg::IOB_DATA_W-1:0]   s_axi_wdata_i,
   input  logic [iob_bus_pkg::IOB_STRB_W-1:0]   s_axi_wstrb_i,
   input  logic                                 s_axi_wlast_i,
   input  logic                                 s_axi_wvalid_i,
   output logic                                 s_axi_wready_o,
   output logic [axi_burst_pkg::AXI_ID_W-1:0]   s_axi_bid_o,
   output logic                                 s_axi_bvalid_o,
   input  logic                                 s_axi_bready_i,
   input  logic [axi_burst_pkg::AXI_ID_W-1:0]   s_axi_arid_i,
   input  logic [iob_bus_pkg::IOB_ADDR_W-1:0]   s_axi_araddr_i,
   input  logic [axi_burst_pkg::AXI_LEN_W-1:0]  s_axi_arlen_i,
   input  logic [axi_burst_pkg::AXI_SIZE_W-1:0] s_axi_arsize_i,
   input  logic                                 s_axi_arvalid_i,
   output logic                                 s_axi_arready_o,
   output logic [axi_burst_pkg::AXI_ID_W-1:0]   s_axi_rid_o,
   output logic [iob_bus_pkg::IOB_DATA_W-1:0]   s_axi_rdata_o,
   output logic                                 s_axi_rlast_o,
   output logic                                 s_axi_rvalid_o,
   input  logic                                 s_axi_rready_i,
   output logic                                 iob_valid_o,
   output logic [iob_bus_pkg::IOB_ADDR_W-1:0]   iob_addr_o,
   output logic [iob_bus_pkg::IOB_DATA_W-1:0]   iob_wdata_o,
   output logic [iob_bus_pkg::IOB_STRB_W-1:0]   iob_wstrb_o,
   input  logic                                 iob_ready_i,
   input  logic                                 iob_rvalid_i,
   input  logic [iob_bus_pkg::IOB_DATA_W-1:0]   iob_rdata_i
);
   import iob_bus_pkg::*;

   logic                  wr_req;
   logic [IOB_ADDR_W-1:0] wr_addr;
   logic [IOB_DATA_W-1:0] wr_wdata;
   logic [IOB_STRB_W-1:0] wr_wstrb;
   logic                  wr_done;
   logic                  rd_req;
   logic [IOB_ADDR_W-1:0] rd_addr;
   logic                  rd_done;

   // Beat count comes from awlen, so s_axi_wlast_i stays unconnected
   axi_wr_burst axi_wr_burst_i (
      .clk_i       (clk_i),
      .arst_i      (arst_i),
      .awid_i      (s_axi_awid_i),
      .awaddr_i    (s_axi_awaddr_i),
      .awlen_i     (s_axi_awlen_i),
      .awsize_i    (s_axi_awsize_i),
      .awvalid_i   (s_axi_awvalid_i),
      .awready_o   (s_axi_awready_o),
      .wdata_i     (s_axi_wdata_i),
      .wstrb_i     (s_axi_wstrb_i),
      .wvalid_i    (s_axi_wvalid_i),
      .wready_o    (s_axi_wready_o),
      .bid_o       (s_axi_bid_o),
      .bvalid_o    (s_axi_bvalid_o),
      .bready_i    (s_axi_bready_i),
      .req_o       (wr_req),
      .req_addr_o  (wr_addr),
      .req_wdata_o (wr_wdata),
      .req_wstrb_o (wr_wstrb),
      .done_i      (wr_done)
   );

   axi_rd_burst axi_rd_burst_i (
      .clk_i      (clk_i),
      .arst_i     (arst_i),
      .arid_i     (s_axi_arid_i),
      .araddr_i   (s_axi_araddr_i),
      .arlen_i    (s_axi_arlen_i),
      .arsize_i   (s_axi_arsize_i),
      .arvalid_i  (s_axi_arvalid_i),
      .arready_o  (s_axi_arready_o),
      .rid_o      (s_axi_rid_o),
      .rdata_o    (s_axi_rdata_o),
      .rlast_o    (s_axi_rlast_o),
      .rvalid_o   (s_axi_rvalid_o),
      .rready_i   (s_axi_rready_i),
      .req_o      (rd_req),
      .req_addr_o (rd_addr),
      .done_i     (rd_done),
      .rdata_i    (iob_rdata_i)
   );

   iob_bus_arbiter iob_bus_arbiter_i (
      .clk_i        (clk_i),
      .arst_i       (arst_i),
      .wr_req_i     (wr_req),
      .wr_addr_i    (wr_addr),
      .wr_wdata_i   (wr_wdata),
      .wr_wstrb_i   (wr_wstrb),
      .wr_done_o    (wr_done),
      .rd_req_i     (rd_req),
      .rd_addr_i    (rd_addr),
      .rd_done_o    (rd_done),
      .iob_valid_o  (iob_valid_o),
      .iob_addr_o   (iob_addr_o),
      .iob_wdata_o  (iob_wdata_o),
      .iob_wstrb_o  (iob_wstrb_o),
      .iob_ready_i  (iob_ready_i),
      .iob_rvalid_i (iob_rvalid_i)
   );

endmodule

// ==== tb/tb_iob_memory.sv ====
/*
 * IOb slave memory model
 * Word array with a stall input on ready and a one-cycle rvalid pulse per read
 */
`timescale 1ns/1ns

module tb_iob_memory (
   input  logic                               clk_i,
   input  logic                               valid_i,
   input  logic [iob_bus_pkg::IOB_ADDR_W-1:0] addr_i,
   input  logic [iob_bus_pkg::IOB_DATA_W-1:0] wdata_i,
   input  logic [iob_bus_pkg::IOB_STRB_W-1:0] wstrb_i,
   input  logic                               stall_i,
   output logic                               ready_o,
   output logic                               rvalid_o,
   output logic [iob_bus_pkg::IOB_DATA_W-1:0] rdata_o
);
   import iob_bus_pkg::*;

   logic [IOB_DATA_W-1:0] mem [0:255];
   logic [IOB_DATA_W-1:0] rd_word;
   logic                  rd_hit;
   int                    i;
   int                    b;

   initial begin
      for (i = 0; i < 256; i++) begin
         mem[i] = (i + 1) * 32'h9e3779b9;
      end
      rvalid_o = 1'b0;
      rdata_o  = '0;
   end

   assign ready_o = ~stall_i;

   // Requests are sampled on the edge, responses change just after it
   always @(posedge clk_i) begin
      rd_hit  = valid_i & ready_o & (wstrb_i == '0);
      rd_word = mem[addr_i[9:2]];
      if (valid_i && ready_o) begin
         for (b = 0; b < IOB_STRB_W; b++) begin
            if (wstrb_i[b]) begin
               mem[addr_i[9:2]][8*b +: 8] = wdata_i[8*b +: 8];
            end
         end
      end
      #2;
      rvalid_o = rd_hit;
      if (rd_hit) begin
         rdata_o = rd_word;
      end
   end

endmodule

// ==== tb/tb_axi2iob.sv ====
/*
 * Testbench for the AXI4 to IOb adapter
 * Runs write and read bursts against an IOb memory model and checks
 * every R and B beat against a shadow copy of the memory
 */
`timescale 1ns/1ns

module tb_axi2iob;
   import axi_burst_pkg::*;
   import iob_bus_pkg::*;

   localparam int          CLK_PERIOD    = 20;
   localparam int          RESET_CYCLES  = 8;
   localparam int          PLANNED_BEATS = 132;
   localparam int          WATCHDOG_NS   = (RESET_CYCLES + 40 * PLANNED_BEATS) * CLK_PERIOD;
   localparam logic [31:0] SEED          = 32'he5ac72b0;
   // Strobe patterns for write bursts
   localparam int          STRB_FULL     = 0;
   localparam int          STRB_RANDOM   = 1;
   localparam int          STRB_SKIP     = 2;
   localparam int          STRB_LANE     = 3;

   typedef struct packed {
      logic [AXI_ID_W-1:0]   id;
      logic [IOB_DATA_W-1:0] data;
      logic                  last;
   } r_beat_t;

   logic [AXI_ID_W-1:0]   s_axi_awid_i, s_axi_bid_o, s_axi_arid_i, s_axi_rid_o;
   logic [IOB_ADDR_W-1:0] s_axi_awaddr_i, s_axi_araddr_i, iob_addr_o;
   logic [AXI_LEN_W-1:0]  s_axi_awlen_i, s_axi_arlen_i;
   logic [AXI_SIZE_W-1:0] s_axi_awsize_i, s_axi_arsize_i;
   logic [IOB_DATA_W-1:0] s_axi_wdata_i, s_axi_rdata_o, iob_wdata_o, iob_rdata_i;
   logic [IOB_STRB_W-1:0] s_axi_wstrb_i, iob_wstrb_o;
   logic clk_i, arst_i, s_axi_awvalid_i, s_axi_awready_o, s_axi_wlast_i, s_axi_wvalid_i;
   logic s_axi_wready_o, s_axi_bvalid_o, s_axi_bready_i, s_axi_arvalid_i, s_axi_arready_o;
   logic s_axi_rlast_o, s_axi_rvalid_o, s_axi_rready_i, iob_valid_o, iob_ready_i, iob_rvalid_i;
   logic stall;

   logic [IOB_DATA_W-1:0] shadow [0:255];
   r_beat_t               exp_r [$];
   r_beat_t               r_exp;
   logic [AXI_ID_W-1:0]   exp_b [$];
   logic [31:0]           wr_seed;
   logic [31:0]           bp_seed;
   int                    exp_writes = 0;
   int                    iob_writes = 0;
   string                 test_name;

   axi2iob_top axi2iob_top_i (.*);

   tb_iob_memory tb_iob_memory_i (
      .clk_i    (clk_i),
      .valid_i  (iob_valid_o),
      .addr_i   (iob_addr_o),
      .wdata_i  (iob_wdata_o),
      .wstrb_i  (iob_wstrb_o),
      .stall_i  (stall),
      .ready_o  (iob_ready_i),
      .rvalid_o (iob_rvalid_i),
      .rdata_o  (iob_rdata_i)
   );

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Power-on contents of the memory model
   function automatic logic [31:0] fill_word(input int idx);
      return (idx + 1) * 32'h9e3779b9;
   endfunction

   function automatic logic [31:0] beat_addr(input logic [31:0] start, input int idx,
                                             input logic [2:0] size);
      return start + idx * (32'd1 << size);
   endfunction

   // Reference model, a write beat lands only in the bytes its strobe enables
   function automatic logic [31:0] merge_word(input logic [31:0] old,
                                              input logic [31:0] data,
                                              input logic [3:0]  strb);
      logic [31:0] word;
      int          b;
      word = old;
      for (b = 0; b < 4; b++) begin
         if (strb[b]) begin
            word[8*b +: 8] = data[8*b +: 8];
         end
      end
      return word;
   endfunction

   task automatic expect_equal(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
      if (expected !== actual) begin
         $display("ERR %s %s: expected %h, actual %h", test_name, what, expected, actual);
         $display("*** TEST FAILED ***");
         $fatal(1, "Mismatch on %s", what);
      end
   endtask

   task automatic step_cycle();
      @(posedge clk_i);
      #2;
   endtask

   task automatic write_burst(input logic [7:0] id, input logic [31:0] addr, input int beats,
                              input logic [2:0] size, input int mode);
      logic [31:0] a;
      logic [3:0]  s;
      int          i;
      exp_b.push_back(id);
      s_axi_awid_i    = id;
      s_axi_awaddr_i  = addr;
      s_axi_awlen_i   = beats - 1;
      s_axi_awsize_i  = size;
      s_axi_awvalid_i = 1'b1;
      while (!s_axi_awready_o) step_cycle();
      step_cycle();
      s_axi_awvalid_i = 1'b0;
      for (i = 0; i < beats; i++) begin
         a       = beat_addr(addr, i, size);
         wr_seed = lcg_next(wr_seed);
         case (mode)
            STRB_FULL:   s = 4'hf;
            STRB_RANDOM: s = wr_seed[27:24];
            STRB_SKIP:   s = (i % 3 == 1) ? 4'h0 : 4'hf;
            default:     s = 4'b0001 << a[1:0];
         endcase
         shadow[a[9:2]] = merge_word(shadow[a[9:2]], wr_seed, s);
         if (s != 4'h0) begin
            exp_writes++;
         end
         s_axi_wdata_i  = wr_seed;
         s_axi_wstrb_i  = s;
         s_axi_wlast_i  = (i == beats - 1);
         s_axi_wvalid_i = 1'b1;
         while (!s_axi_wready_o) step_cycle();
         step_cycle();
         s_axi_wvalid_i = 1'b0;
      end
      do begin
         step_cycle();
      end while (exp_b.size() != 0);
   endtask

   task automatic read_burst(input logic [7:0] id, input logic [31:0] addr, input int beats,
                             input logic [2:0] size);
      logic [31:0] a;
      int          i;
      for (i = 0; i < beats; i++) begin
         a = beat_addr(addr, i, size);
         exp_r.push_back('{id, shadow[a[9:2]], i == beats - 1});
      end
      s_axi_arid_i    = id;
      s_axi_araddr_i  = addr;
      s_axi_arlen_i   = beats - 1;
      s_axi_arsize_i  = size;
      s_axi_arvalid_i = 1'b1;
      while (!s_axi_arready_o) step_cycle();
      step_cycle();
      s_axi_arvalid_i = 1'b0;
      do begin
         step_cycle();
      end while (exp_r.size() != 0);
   endtask

   always #(CLK_PERIOD / 2) clk_i = ~clk_i;

   // Random back-pressure and IOb stalls
   always @(posedge clk_i) begin
      #2;
      bp_seed        = lcg_next(bp_seed);
      s_axi_rready_i = bp_seed[31:30] != 2'b00;
      s_axi_bready_i = bp_seed[29:28] != 2'b00;
      stall          = bp_seed[27:26] == 2'b00;
   end

   // Compare process for R beats, B responses and IOb writes
   always @(posedge clk_i) begin
      if (iob_valid_o && iob_ready_i && iob_wstrb_o != '0) begin
         iob_writes++;
      end
      if (s_axi_rvalid_o && s_axi_rready_i) begin
         expect_equal("R beat pending", 1, exp_r.size() > 0);
         r_exp = exp_r.pop_front();
         expect_equal("rdata", r_exp.data, s_axi_rdata_o);
         expect_equal("rid", r_exp.id, s_axi_rid_o);
         expect_equal("rlast", r_exp.last, s_axi_rlast_o);
      end
      if (s_axi_bvalid_o && s_axi_bready_i) begin
         expect_equal("B response pending", 1, exp_b.size() > 0);
         expect_equal("bid", exp_b.pop_front(), s_axi_bid_o);
      end
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog timeout: the DUT stopped responding and the test hung");
      $display("*** TEST FAILED ***");
      $fatal(1, "Timeout after %0d ns", WATCHDOG_NS);
   end

   initial begin
      int i;
      clk_i  = 1'b0;
      arst_i = 1'b1;
      {s_axi_awid_i, s_axi_awaddr_i, s_axi_awlen_i, s_axi_awsize_i, s_axi_awvalid_i} = '0;
      {s_axi_wdata_i, s_axi_wstrb_i, s_axi_wlast_i, s_axi_wvalid_i, s_axi_bready_i} = '0;
      {s_axi_arid_i, s_axi_araddr_i, s_axi_arlen_i, s_axi_arsize_i, s_axi_arvalid_i} = '0;
      s_axi_rready_i = 1'b0;
      stall          = 1'b0;
      wr_seed        = SEED;
      bp_seed        = ~SEED;
      for (i = 0; i < 256; i++) begin
         shadow[i] = fill_word(i);
      end
      repeat (RESET_CYCLES) @(posedge clk_i);
      #2;
      arst_i = 1'b0;

      test_name = "single_beat";
      write_burst(8'h11, 32'h010, 1, 3'd2, STRB_FULL);
      read_burst(8'h12, 32'h010, 1, 3'd2);
      test_name = "burst16";
      write_burst(8'h21, 32'h100, 16, 3'd2, STRB_FULL);
      read_burst(8'h22, 32'h100, 16, 3'd2);
      test_name = "partial_strobe";
      write_burst(8'h31, 32'h100, 8, 3'd2, STRB_RANDOM);
      read_burst(8'h32, 32'h100, 8, 3'd2);
      // Beats 1, 4 and 7 carry no strobe and must not reach the IOb port
      test_name = "zero_strobe";
      write_burst(8'h41, 32'h200, 9, 3'd2, STRB_SKIP);
      expect_equal("IOb writes", exp_writes, iob_writes);
      read_burst(8'h42, 32'h200, 9, 3'd2);
      test_name = "byte_size";
      write_burst(8'h51, 32'h302, 8, 3'd0, STRB_LANE);
      read_burst(8'h52, 32'h302, 8, 3'd0);
      test_name = "overlap";
      fork
         write_burst(8'h61, 32'h080, 16, 3'd2, STRB_RANDOM);
         read_burst(8'h62, 32'h100, 16, 3'd2);
      join
      read_burst(8'h63, 32'h080, 16, 3'd2);
      expect_equal("IOb writes", exp_writes, iob_writes);

      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

// ==== vlog.f ====
verilog/axi_burst_pkg.sv
verilog/iob_bus_pkg.sv
verilog/axi_wr_burst.sv
verilog/axi_rd_burst.sv
verilog/iob_bus_arbiter.sv
verilog/axi2iob_top.sv
tb/tb_iob_memory.sv
tb/tb_axi2iob.sv
